// File: hw/bus_pkg.sv
// Bus request and response structs for the harness interconnect
// Host and device enums with their counts

package bus_pkg;

  // Host request, also the request forwarded to a device
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Response to a host, devices leave gnt low
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  // Hosts in decreasing priority
  typedef enum logic [1:0] {
    TestUtilHost,
    CoreD,
    CoreI
  } bus_host_e;

  typedef enum logic {
    Ram,
    TestUtilDevice
  } bus_device_e;

  localparam int unsigned NrHosts   = 3;
  localparam int unsigned NrDevices = 2;

endpackage

// File: hw/harness_pkg.sv
// Memory map of the compliance harness
// Register offsets inside the test utility window

package harness_pkg;

  // RAM starts at zero, its size comes from the RamDepth parameter
  localparam logic [31:0] RamBase = 32'h0000_0000;

  // Test utility occupies a 1 kB window
  localparam logic [31:0] TestUtilBase = 32'h0002_0000;
  localparam logic [31:0] TestUtilMask = ~32'h0000_03FF;

  // Offset width inside the test utility window
  localparam int unsigned TestUtilOffsetW = 10;

  // Signature region bounds, end is exclusive
  localparam logic [TestUtilOffsetW-1:0] SigStartOffset = 10'h000;
  localparam logic [TestUtilOffsetW-1:0] SigEndOffset   = 10'h004;

  // Any write here starts the signature dump
  localparam logic [TestUtilOffsetW-1:0] HaltOffset     = 10'h008;

endpackage

// File: hw/bus.sv
// Fixed-priority simple bus for three hosts and two devices
// Arbiter, address decoder and one-entry response router

`timescale 1ns/1ps

module bus #(
  parameter int unsigned RamDepth = 16384
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  bus_pkg::bus_req_t host_req_i [bus_pkg::NrHosts],
  output bus_pkg::bus_rsp_t host_rsp_o [bus_pkg::NrHosts],

  output bus_pkg::bus_req_t dev_req_o  [bus_pkg::NrDevices],
  input  bus_pkg::bus_rsp_t dev_rsp_i  [bus_pkg::NrDevices]
);

  // RAM window covers RamDepth words from RamBase
  localparam logic [31:0] RamMask = ~32'(RamDepth * 4 - 1);

  // Current arbitration result
  logic                  win_valid;
  bus_pkg::bus_host_e    win_host;
  bus_pkg::bus_req_t     win_req;

  // Address decode of the winning request
  logic                  ram_hit;
  logic                  tu_hit;
  logic                  dev_hit;
  bus_pkg::bus_device_e  dev_sel;

  // Record of last cycle's grant for response routing
  logic                  rsp_valid_q;
  bus_pkg::bus_host_e    rsp_host_q;
  bus_pkg::bus_device_e  rsp_dev_q;
  logic                  rsp_miss_q;

  bus_pkg::bus_rsp_t     sel_rsp;
  logic                  rsp_ok;

  // Lowest index wins, so scan from the bottom of the priority list
  always_comb begin
    win_valid = 1'b0;
    win_host  = bus_pkg::TestUtilHost;
    for (int h = bus_pkg::NrHosts - 1; h >= 0; h--) begin
      if (host_req_i[h].req) begin
        win_valid = 1'b1;
        win_host  = bus_pkg::bus_host_e'(2'(h));
      end
    end
  end

  assign win_req = host_req_i[win_host];

  // Address decode
  assign ram_hit = (win_req.addr & RamMask) == harness_pkg::RamBase;
  assign tu_hit  = (win_req.addr & harness_pkg::TestUtilMask) == harness_pkg::TestUtilBase;
  assign dev_hit = ram_hit || tu_hit;

  always_comb begin
    dev_sel = bus_pkg::Ram;
    if (tu_hit) begin
      dev_sel = bus_pkg::TestUtilDevice;
    end
  end

  // Forward to at most one device
  always_comb begin
    for (int d = 0; d < bus_pkg::NrDevices; d++) begin
      dev_req_o[d]     = win_req;
      dev_req_o[d].req = win_valid && dev_hit && (dev_sel == 1'(d));
    end
  end

  // Unmapped requests are still granted and answered with err
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_host_q  <= bus_pkg::TestUtilHost;
      rsp_dev_q   <= bus_pkg::Ram;
      rsp_miss_q  <= 1'b0;
    end else begin
      rsp_valid_q <= win_valid;
      rsp_host_q  <= win_host;
      rsp_dev_q   <= dev_sel;
      rsp_miss_q  <= !dev_hit;
    end
  end

  assign sel_rsp = dev_rsp_i[rsp_dev_q];
  assign rsp_ok  = rsp_miss_q || sel_rsp.rvalid;

  // Grant and route the response back to its host
  always_comb begin
    for (int h = 0; h < bus_pkg::NrHosts; h++) begin
      host_rsp_o[h]     = '0;
      host_rsp_o[h].gnt = win_valid && (win_host == 2'(h));
      if (rsp_valid_q && rsp_ok && (rsp_host_q == 2'(h))) begin
        host_rsp_o[h].rvalid = 1'b1;
        if (rsp_miss_q) begin
          host_rsp_o[h].err = 1'b1;
        end else begin
          host_rsp_o[h].err   = sel_rsp.err;
          host_rsp_o[h].rdata = sel_rsp.rdata;
        end
      end
    end
  end

endmodule

// File: hw/ram_1p.sv
// Single-port word RAM with byte enables
// Answers every request one cycle later

`timescale 1ns/1ps

module ram_1p #(
  parameter int unsigned RamDepth = 16384
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  bus_pkg::bus_req_t req_i,
  output bus_pkg::bus_rsp_t rsp_o
);

  localparam int unsigned AddrW = $clog2(RamDepth);

  logic [31:0]      mem [RamDepth];
  logic [AddrW-1:0] word_addr;
  logic             rvalid_q;
  logic [31:0]      rdata_q;

  // Word index wraps modulo RamDepth
  assign word_addr = req_i.addr[AddrW+1:2];

  // Only enabled lanes change
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (req_i.be[i]) begin
          mem[word_addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? 32'h0 : mem[word_addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = 1'b0;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = 1'b0;
  assign rsp_o.rdata  = rdata_q;

endmodule

// File: hw/riscv_testutil.sv
// Test utility device with signature bounds and halt register
// Host engine that reads the signature region and streams it out

`timescale 1ns/1ps

module riscv_testutil (
  input  logic              clk_i,
  input  logic              rst_i,

  input  bus_pkg::bus_req_t dev_req_i,
  output bus_pkg::bus_rsp_t dev_rsp_o,

  output bus_pkg::bus_req_t host_req_o,
  input  bus_pkg::bus_rsp_t host_rsp_i,

  output logic              sig_valid_o,
  output logic [31:0]       sig_data_o,
  output logic              done_o
);

  typedef enum logic [1:0] {
    StIdle,
    StDump,
    StFinish
  } state_e;

  logic [harness_pkg::TestUtilOffsetW-1:0] offset;
  logic        dev_wr;
  logic        known_off;
  logic [31:0] rd_mux;

  logic [31:0] sig_start_q;
  logic [31:0] sig_end_q;
  logic        dev_rvalid_q;
  logic        dev_err_q;
  logic [31:0] dev_rdata_q;

  state_e      state_q;
  logic        dump_start;
  logic [31:0] span;
  logic [29:0] issue_cnt_q;
  logic [31:0] addr_q;
  logic [1:0]  out_q;
  logic [1:0]  out_next;

  // Device side decode
  assign offset    = dev_req_i.addr[harness_pkg::TestUtilOffsetW-1:0];
  assign dev_wr    = dev_req_i.req && dev_req_i.we;
  assign known_off = (offset == harness_pkg::SigStartOffset) ||
                     (offset == harness_pkg::SigEndOffset) ||
                     (offset == harness_pkg::HaltOffset);

  always_comb begin
    case (offset)
      harness_pkg::SigStartOffset: rd_mux = sig_start_q;
      harness_pkg::SigEndOffset:   rd_mux = sig_end_q;
      default:                     rd_mux = 32'h0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sig_start_q <= 32'h0;
      sig_end_q   <= 32'h0;
    end else if (dev_wr) begin
      for (int i = 0; i < 4; i++) begin
        if (dev_req_i.be[i] && offset == harness_pkg::SigStartOffset) begin
          sig_start_q[8*i +: 8] <= dev_req_i.wdata[8*i +: 8];
        end
        if (dev_req_i.be[i] && offset == harness_pkg::SigEndOffset) begin
          sig_end_q[8*i +: 8] <= dev_req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dev_rvalid_q <= 1'b0;
      dev_err_q    <= 1'b0;
    end else begin
      dev_rvalid_q <= dev_req_i.req;
      dev_err_q    <= dev_req_i.req && !known_off;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_req_i.req) begin
      dev_rdata_q <= dev_req_i.we ? 32'h0 : rd_mux;
    end
  end

  assign dev_rsp_o.gnt    = 1'b0;
  assign dev_rsp_o.rvalid = dev_rvalid_q;
  assign dev_rsp_o.err    = dev_err_q;
  assign dev_rsp_o.rdata  = dev_rdata_q;

  // Halt writes outside idle are dropped
  assign dump_start = dev_wr && (offset == harness_pkg::HaltOffset) && (state_q == StIdle);
  assign span       = sig_end_q - sig_start_q;

  // Reads in flight, counted up on gnt and down on rvalid
  assign out_next = out_q + {1'b0, host_rsp_i.gnt} - {1'b0, host_rsp_i.rvalid};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= StIdle;
      issue_cnt_q <= '0;
      addr_q      <= 32'h0;
      out_q       <= 2'd0;
    end else begin
      out_q <= out_next;
      case (state_q)
        StIdle: begin
          if (dump_start) begin
            state_q     <= StDump;
            addr_q      <= sig_start_q;
            issue_cnt_q <= (sig_end_q > sig_start_q) ? span[31:2] : '0;
          end
        end
        StDump: begin
          if (host_rsp_i.gnt) begin
            addr_q      <= addr_q + 32'd4;
            issue_cnt_q <= issue_cnt_q - 30'd1;
          end
          // Leave as the last word returns so done follows it directly
          if (issue_cnt_q == '0 && out_next == 2'd0) begin
            state_q <= StFinish;
          end
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

  // Word reads from the signature region
  assign host_req_o.req   = (state_q == StDump) && (issue_cnt_q != '0);
  assign host_req_o.we    = 1'b0;
  assign host_req_o.be    = 4'hF;
  assign host_req_o.addr  = addr_q;
  assign host_req_o.wdata = 32'h0;

  assign sig_valid_o = host_rsp_i.rvalid && (state_q == StDump);
  assign sig_data_o  = host_rsp_i.rdata;
  assign done_o      = (state_q == StFinish);

endmodule

// File: hw/compliance_harness.sv
// Compliance harness top level
// Bus with RAM and test utility, core host ports brought out

`timescale 1ns/1ps

module compliance_harness #(
  parameter int unsigned RamDepth = 16384
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  bus_pkg::bus_req_t core_d_req_i,
  output bus_pkg::bus_rsp_t core_d_rsp_o,
  input  bus_pkg::bus_req_t core_i_req_i,
  output bus_pkg::bus_rsp_t core_i_rsp_o,

  output logic              sig_valid_o,
  output logic [31:0]       sig_data_o,
  output logic              done_o
);

  bus_pkg::bus_req_t host_req [bus_pkg::NrHosts];
  bus_pkg::bus_rsp_t host_rsp [bus_pkg::NrHosts];
  bus_pkg::bus_req_t dev_req  [bus_pkg::NrDevices];
  bus_pkg::bus_rsp_t dev_rsp  [bus_pkg::NrDevices];

  // Core ports take the two lower priority host slots
  assign host_req[bus_pkg::CoreD] = core_d_req_i;
  assign host_req[bus_pkg::CoreI] = core_i_req_i;
  assign core_d_rsp_o = host_rsp[bus_pkg::CoreD];
  assign core_i_rsp_o = host_rsp[bus_pkg::CoreI];

  bus #(
    .RamDepth (RamDepth)
  ) u_bus (
    .clk_i      (clk_i   ),
    .rst_i      (rst_i   ),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .dev_req_o  (dev_req ),
    .dev_rsp_i  (dev_rsp )
  );

  ram_1p #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_i (clk_i               ),
    .rst_i (rst_i               ),
    .req_i (dev_req[bus_pkg::Ram]),
    .rsp_o (dev_rsp[bus_pkg::Ram])
  );

  // Device for the register window, host while dumping
  riscv_testutil u_riscv_testutil (
    .clk_i       (clk_i                             ),
    .rst_i       (rst_i                             ),
    .dev_req_i   (dev_req[bus_pkg::TestUtilDevice]  ),
    .dev_rsp_o   (dev_rsp[bus_pkg::TestUtilDevice]  ),
    .host_req_o  (host_req[bus_pkg::TestUtilHost]   ),
    .host_rsp_i  (host_rsp[bus_pkg::TestUtilHost]   ),
    .sig_valid_o (sig_valid_o                       ),
    .sig_data_o  (sig_data_o                        ),
    .done_o      (done_o                            )
  );

endmodule

// File: verification/compliance_harness_chk.sv
// Bound checks on the bus, attached to every bus instance
// Fixed-priority grant, one-cycle rvalid, request hold and error data

`timescale 1ns/1ps

module compliance_harness_chk (
  input logic              clk_i,
  input logic              rst_i,
  input bus_pkg::bus_req_t host_req_i [bus_pkg::NrHosts],
  input bus_pkg::bus_rsp_t host_rsp_i [bus_pkg::NrHosts]
);

  logic [bus_pkg::NrHosts-1:0] req_vec;
  logic [bus_pkg::NrHosts-1:0] gnt_vec;
  logic [bus_pkg::NrHosts-1:0] rvalid_vec;
  logic [bus_pkg::NrHosts-1:0] err_data_vec;

  int unsigned prio_fail_cnt = 0;
  int unsigned timing_fail_cnt = 0;
  int unsigned hold_fail_cnt = 0;
  int unsigned err_fail_cnt = 0;
  int unsigned fail_cnt;

  always_comb begin
    for (int h = 0; h < bus_pkg::NrHosts; h++) begin
      req_vec[h]      = host_req_i[h].req;
      gnt_vec[h]      = host_rsp_i[h].gnt;
      rvalid_vec[h]   = host_rsp_i[h].rvalid;
      err_data_vec[h] = host_rsp_i[h].rvalid && host_rsp_i[h].err &&
                        (host_rsp_i[h].rdata != 32'h0);
    end
  end

  // Lowest requesting index gets the only grant
  a_grant_priority: assert property (@(posedge clk_i) disable iff (rst_i)
    gnt_vec == (req_vec & (~req_vec + 3'd1)))
  else begin
    prio_fail_cnt++;
    $error("grant does not follow fixed priority");
  end

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_vec == $past(gnt_vec))
  else begin
    timing_fail_cnt++;
    $error("rvalid does not follow its grant by one cycle");
  end

  // A host that lost arbitration keeps its request up
  a_hold_until_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (($past(req_vec) & ~$past(gnt_vec)) & ~req_vec) == '0)
  else begin
    hold_fail_cnt++;
    $error("request dropped before grant");
  end

  a_err_zero_data: assert property (@(posedge clk_i) disable iff (rst_i)
    err_data_vec == '0)
  else begin
    err_fail_cnt++;
    $error("error response carries nonzero rdata");
  end

  assign fail_cnt = prio_fail_cnt + timing_fail_cnt + hold_fail_cnt + err_fail_cnt;

endmodule

bind bus compliance_harness_chk u_chk (
  .clk_i      (clk_i     ),
  .rst_i      (rst_i     ),
  .host_req_i (host_req_i),
  .host_rsp_i (host_rsp_o)
);

// File: verification/compliance_harness_tb.sv
// Testbench for the compliance harness
// Drives both core ports and checks against a reference memory model

`timescale 1ns/1ps

module compliance_harness_tb;

  localparam int unsigned RamDepth = 1024;
  // Tests take under 200 cycles including reset and the dump
  localparam int unsigned TimeoutCycles = 3000;
  localparam int unsigned SigWords = 6;
  localparam logic [31:0] SigAddr = 32'h0000_0800;

  logic              clk;
  logic              rst;
  bus_pkg::bus_req_t d_req;
  bus_pkg::bus_rsp_t d_rsp;
  bus_pkg::bus_req_t i_req;
  bus_pkg::bus_rsp_t i_rsp;
  logic              sig_valid;
  logic [31:0]       sig_data;
  logic              done;

  int unsigned cycle = 0;
  int unsigned tb_errors = 0;
  string       test_name;
  logic [31:0] ref_mem [int unsigned];
  logic [31:0] sig_q [$];
  int unsigned word_q [$];

  compliance_harness #(
    .RamDepth (RamDepth)
  ) u_dut (
    .clk_i        (clk      ),
    .rst_i        (rst      ),
    .core_d_req_i (d_req    ),
    .core_d_rsp_o (d_rsp    ),
    .core_i_req_i (i_req    ),
    .core_i_rsp_o (i_rsp    ),
    .sig_valid_o  (sig_valid),
    .sig_data_o   (sig_data ),
    .done_o       (done     )
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle++;
    if (cycle == TimeoutCycles) begin
      $display("timeout after %0d cycles without reaching the end of the tests", cycle);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      tb_errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_true(input string what, input bit cond);
    assert (cond) else begin
      tb_errors++;
      $display("error in %s: %s did not hold", test_name, what);
    end
  endtask

  // Byte lanes with be set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                               input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // One transfer on the data or instruction port
  // Request stays up until gnt
  task automatic bus_access(input bit use_i, input bit we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err,
                            output int unsigned gnt_cyc);
    bus_pkg::bus_req_t r;
    bus_pkg::bus_rsp_t rsp;
    r       = '0;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    @(posedge clk);
    #1;
    if (use_i) i_req = r;
    else d_req = r;
    do begin
      @(negedge clk);
      rsp = use_i ? i_rsp : d_rsp;
    end while (!rsp.gnt);
    gnt_cyc = cycle;
    @(posedge clk);
    #1;
    if (use_i) i_req = '0;
    else d_req = '0;
    @(negedge clk);
    rsp = use_i ? i_rsp : d_rsp;
    check_true("rvalid one cycle after gnt", rsp.rvalid);
    rdata = rsp.rdata;
    err   = rsp.err;
  endtask

  task automatic write_word(input int unsigned idx, input logic [31:0] wdata,
                            input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    int unsigned gnt_cyc;
    logic [31:0] old;
    old = ref_mem.exists(idx) ? ref_mem[idx] : 32'h0;
    bus_access(1'b0, 1'b1, be, idx * 4, wdata, rdata, err, gnt_cyc);
    check_true("RAM write without error", !err);
    ref_mem[idx] = merge_bytes(old, wdata, be);
  endtask

  task automatic read_check(input bit use_i, input int unsigned idx, output int unsigned gnt_cyc);
    logic [31:0] rdata;
    logic        err;
    bus_access(use_i, 1'b0, 4'hF, idx * 4, 32'h0, rdata, err, gnt_cyc);
    check_true("RAM read without error", !err);
    check_value($sformatf("word %0d", idx), ref_mem[idx], rdata);
  endtask

  task automatic expect_error(input logic [31:0] addr, input bit we);
    logic [31:0] rdata;
    logic        err;
    int unsigned gnt_cyc;
    bus_access(1'b0, we, 4'hF, addr, 32'hDEAD_BEEF, rdata, err, gnt_cyc);
    check_true($sformatf("err set for address %h", addr), err);
    check_value("rdata on error", 32'h0, rdata);
  endtask

  task automatic reg_access(input logic [harness_pkg::TestUtilOffsetW-1:0] offset, input bit we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic        err;
    int unsigned gnt_cyc;
    bus_access(1'b0, we, 4'hF, harness_pkg::TestUtilBase + 32'(offset), wdata, rdata, err,
               gnt_cyc);
    check_true("test utility register access without error", !err);
  endtask

  // Words in address order followed by one done pulse
  task automatic collect_signature();
    int unsigned got;
    bit          finished;
    got      = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      if (sig_valid) begin
        if (got < sig_q.size()) begin
          check_value($sformatf("signature word %0d", got), sig_q[got], sig_data);
        end
        got++;
      end
      if (done) begin
        check_true("no signature word alongside done", !sig_valid);
        finished = 1'b1;
      end
    end
    check_value("signature word count", 32'(sig_q.size()), got);
    @(negedge clk);
    check_true("done lasts one cycle", !done);
  endtask

  initial begin
    int unsigned idx;
    int unsigned d_cyc;
    int unsigned i_cyc;
    int unsigned gnt_cyc;
    int unsigned chk_errors;
    logic [31:0] rdata;

    void'($urandom(32'h6a9ff799));
    clk   = 1'b0;
    rst   = 1'b1;
    d_req = '0;
    i_req = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "idle after reset";
    repeat (4) begin
      @(negedge clk);
      check_true("no bus activity", !(d_rsp.gnt || d_rsp.rvalid || i_rsp.gnt || i_rsp.rvalid));
      check_true("no signature activity", !(sig_valid || done));
    end

    test_name = "data port write and read";
    for (int k = 0; k < 8; k++) begin
      idx = $urandom_range(255, 0);
      word_q.push_back(idx);
      write_word(idx, $urandom, 4'hF);
      write_word(idx, $urandom, 4'($urandom));
    end
    foreach (word_q[k]) begin
      read_check(1'b0, word_q[k], gnt_cyc);
    end

    test_name = "instruction port read";
    foreach (word_q[k]) begin
      read_check(1'b1, word_q[k], gnt_cyc);
    end

    test_name = "simultaneous requests";
    fork
      read_check(1'b0, word_q[0], d_cyc);
      read_check(1'b1, word_q[1], i_cyc);
    join
    check_true("data port granted before instruction port", d_cyc < i_cyc);

    test_name = "unmapped and bad offset";
    expect_error(32'h1000_0000, 1'b0);
    // First word past the RAM window
    expect_error(32'h0000_1000, 1'b1);
    expect_error(harness_pkg::TestUtilBase + 32'h0C, 1'b0);
    expect_error(harness_pkg::TestUtilBase + 32'h10, 1'b1);

    test_name = "signature dump";
    for (int k = 0; k < SigWords; k++) begin
      idx = SigAddr / 4 + k;
      write_word(idx, $urandom, 4'hF);
      sig_q.push_back(ref_mem[idx]);
    end
    reg_access(harness_pkg::SigStartOffset, 1'b1, SigAddr, rdata);
    reg_access(harness_pkg::SigEndOffset, 1'b1, SigAddr + SigWords * 4, rdata);
    reg_access(harness_pkg::SigStartOffset, 1'b0, 32'h0, rdata);
    check_value("start register", SigAddr, rdata);
    reg_access(harness_pkg::SigEndOffset, 1'b0, 32'h0, rdata);
    check_value("end register", SigAddr + SigWords * 4, rdata);
    reg_access(harness_pkg::HaltOffset, 1'b1, 32'h1, rdata);
    fork
      collect_signature();
      begin
        write_word(word_q[2], $urandom, 4'hF);
        read_check(1'b0, word_q[2], gnt_cyc);
      end
    join

    repeat (4) @(negedge clk);
    chk_errors = u_dut.u_bus.u_chk.fail_cnt;
    $display("errors: testbench %0d, bound assertions %0d", tb_errors, chk_errors);
    if (tb_errors == 0 && chk_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: compliance_harness.f
hw/bus_pkg.sv
hw/harness_pkg.sv
hw/bus.sv
hw/ram_1p.sv
hw/riscv_testutil.sv
hw/compliance_harness.sv
verification/compliance_harness_chk.sv
verification/compliance_harness_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the compliance harness testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
  --top-module compliance_harness_tb \
  --Mdir obj_dir -o sim \
  -f compliance_harness.f

# Let assertion failures run on to the testbench summary
status=0
./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
